//--- sources.f
source/mem_pkg.sv
source/mem_stage.sv
source/mem_cfg_regs.sv
source/data_sram.sv
source/mem_subsys_top.sv
verification/tb_clock.sv
verification/mem_chk.sv
verification/mem_tb.sv

//--- Makefile
# Verilator build and run of the memory stage testbench
SIM  := obj_dir/mem_sim
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qxF '** PASS **' sim.log

$(SIM): sources.f $(SRCS)
	verilator --binary --assert --top-module mem_tb -f sources.f -Mdir obj_dir -o mem_sim

clean:
	rm -rf obj_dir sim.log

//--- verification/mem_stim.txt
// group ctrl op addr wdata rd, then expected we wdata excp_code (all hex)
// ctrl: 0 issue with gap, 1 issue back to back, 2 LL bit clear, 3 config write of wdata[0]
1 0 9 00000100 8899aabb 01 0 00000000 00
1 0 7 00000104 00000081 02 0 00000000 00
1 0 7 00000105 0000007f 03 0 00000000 00
1 0 7 00000106 000000fe 04 0 00000000 00
1 0 7 00000107 12345601 05 0 00000000 00
1 0 8 00000108 00008001 06 0 00000000 00
1 0 8 0000010a abcd7ffe 07 0 00000000 00
1 0 1 00000100 00000000 08 1 ffffffbb 00
1 0 2 00000101 00000000 09 1 000000aa 00
1 0 1 00000103 00000000 0a 1 ffffff88 00
1 0 2 00000106 00000000 0b 1 000000fe 00
1 0 1 00000106 00000000 0c 1 fffffffe 00
1 0 1 00000105 00000000 0d 1 0000007f 00
1 0 3 00000102 00000000 0e 1 ffff8899 00
1 0 4 00000100 00000000 0f 1 0000aabb 00
1 0 3 00000108 00000000 10 1 ffff8001 00
1 0 4 0000010a 00000000 11 1 00007ffe 00
1 0 3 0000010a 00000000 12 1 00007ffe 00
1 0 5 00000100 00000000 13 1 8899aabb 00
1 0 5 00000104 00000000 14 1 01fe7f81 00
2 0 6 00000200 00000000 01 1 00000000 00
2 0 a 00000200 cafef00d 02 1 00000001 00
2 0 5 00000200 00000000 03 1 cafef00d 00
2 0 a 00000200 11111111 04 1 00000000 00
2 0 5 00000200 00000000 05 1 cafef00d 00
2 0 6 00000200 00000000 06 1 cafef00d 00
2 2 0 00000000 00000000 00 0 00000000 00
2 0 a 00000200 22222222 07 1 00000000 00
2 0 5 00000200 00000000 08 1 cafef00d 00
3 0 3 00000101 00000000 01 0 00000000 09
3 0 5 00000102 00000000 02 0 00000000 09
3 0 9 00000201 deadbeef 03 0 00000000 09
3 0 a 00000202 deadbeef 04 0 00000000 09
4 3 0 00000000 00000000 00 0 00000000 00
4 0 5 00000102 00000000 01 1 00000000 00
4 0 4 00000109 00000000 02 1 00000000 00
4 0 9 00000101 deadbeef 03 0 00000000 00
4 0 5 00000100 00000000 04 1 8899aabb 00
4 3 0 00000000 00000001 00 0 00000000 00
4 0 3 00000103 00000000 05 0 00000000 09
5 1 9 00000300 5a5aa5a5 01 0 00000000 00
5 1 5 00000300 00000000 02 1 5a5aa5a5 00
5 1 5 00000104 00000000 03 1 01fe7f81 00
5 1 1 00000100 00000000 04 1 ffffffbb 00
5 1 4 0000010a 00000000 05 1 00007ffe 00
5 1 5 00000200 00000000 06 1 cafef00d 00
5 1 2 00000107 00000000 07 1 00000001 00

//--- verification/mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_tb;
    import mem_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 9;

    // Control column of the stimulus file
    localparam logic [3:0] CTRL_GAP   = 4'd0;
    localparam logic [3:0] CTRL_B2B   = 4'd1;
    localparam logic [3:0] CTRL_LLCLR = 4'd2;
    localparam logic [3:0] CTRL_CFG   = 4'd3;

    logic       clk;
    logic       rst_i;
    logic       ex_valid_i;
    mem_op_t    ex_op_i;
    addr_t      ex_addr_i;
    word_t      ex_wdata_i;
    reg_idx_t   ex_waddr_i;
    logic       stall_o;
    logic       cfg_we_i;
    logic       cfg_align_chk_i;
    logic       llbit_clr_i;
    logic       wb_valid_o;
    logic       wb_we_o;
    reg_idx_t   wb_waddr_o;
    word_t      wb_wdata_o;
    logic       wb_excp_o;
    excp_code_t wb_excp_code_o;

    logic [31:0] stim_mem [FIELDS*MAX_LINES];
    int n_lines     = 0;
    int cycle_limit = 0;
    int cycles      = 0;
    int errors      = 0;
    int checks      = 0;
    int stall_hits  = 0;
    logic burst_seen = 1'b0;

    // Expected results, in acceptance order
    mem_op_t    exp_op   [$];
    reg_idx_t   exp_rd   [$];
    logic       exp_we   [$];
    word_t      exp_data [$];
    excp_code_t exp_code [$];

    tb_clock clk_gen_i (.clk_o(clk));

    mem_subsys_top dut_i (
        .clk, .rst_i,
        .ex_valid_i, .ex_op_i, .ex_addr_i, .ex_wdata_i, .ex_waddr_i, .stall_o,
        .cfg_we_i, .cfg_align_chk_i, .llbit_clr_i,
        .wb_valid_o, .wb_we_o, .wb_waddr_o, .wb_wdata_o, .wb_excp_o, .wb_excp_code_o
    );

    task automatic check_word(input string name, input mem_op_t op,
                              input word_t exp, input word_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %08h, got %08h (op %0d)",
                     $time, name, exp, got, op);
        end
    endtask

    task automatic check_reg(input string name, input mem_op_t op,
                             input reg_idx_t exp, input reg_idx_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d, got %0d (op %0d)",
                     $time, name, exp, got, op);
        end
    endtask

    task automatic check_excp(input string name, input mem_op_t op,
                              input excp_code_t exp, input excp_code_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %02h, got %02h (op %0d)",
                     $time, name, exp, got, op);
        end
    endtask

    task automatic check_bit(input string name, input mem_op_t op,
                             input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %b, got %b (op %0d)",
                     $time, name, exp, got, op);
        end
    endtask

    function automatic int field(input int line, input int col);
        return int'(stim_mem[line*FIELDS + col]);
    endfunction

    function automatic string group_name(input int grp);
        case (grp)
            0:       return "reset";
            1:       return "load/store widths";
            2:       return "LL/SC";
            3:       return "misaligned, check on";
            4:       return "misaligned, check off";
            5:       return "back-to-back burst";
            default: return "other";
        endcase
    endfunction

    task automatic load_stim();
        foreach (stim_mem[k]) begin
            stim_mem[k] = '0;
        end
        $readmemh("verification/mem_stim.txt", stim_mem);
        while (n_lines < MAX_LINES && stim_mem[n_lines*FIELDS] != '0) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            errors++;
            $display("No stimulus lines could be read from verification/mem_stim.txt");
        end
    endtask

    // Called at a falling edge, returns at a falling edge
    task automatic run_line(input int i);
        int base;
        int gap;
        logic [3:0] ctrl;
        base = i * FIELDS;
        ctrl = stim_mem[base+1][3:0];
        case (ctrl)
            CTRL_LLCLR: begin
                ex_valid_i  = 1'b0;
                llbit_clr_i = 1'b1;
                @(negedge clk);
                llbit_clr_i = 1'b0;
            end
            CTRL_CFG: begin
                ex_valid_i      = 1'b0;
                cfg_we_i        = 1'b1;
                cfg_align_chk_i = stim_mem[base+4][0];
                @(negedge clk);
                cfg_we_i        = 1'b0;
            end
            default: begin
                ex_valid_i = 1'b1;
                ex_op_i    = stim_mem[base+2][3:0];
                ex_addr_i  = stim_mem[base+3];
                ex_wdata_i = stim_mem[base+4];
                ex_waddr_i = stim_mem[base+5][4:0];
                if (ctrl == CTRL_B2B) begin
                    burst_seen = 1'b1;
                end
                // Settled stall decides acceptance at the coming rising edge
                #1;
                while (stall_o) begin
                    stall_hits++;
                    @(negedge clk);
                    #1;
                end
                exp_op.push_back(stim_mem[base+2][3:0]);
                exp_rd.push_back(stim_mem[base+5][4:0]);
                exp_we.push_back(stim_mem[base+6][0]);
                exp_data.push_back(stim_mem[base+7]);
                exp_code.push_back(stim_mem[base+8][5:0]);
                @(negedge clk);
                if (ctrl == CTRL_GAP) begin
                    ex_valid_i = 1'b0;
                    gap = $urandom % 3;
                    repeat (gap) @(negedge clk);
                end
            end
        endcase
    endtask

    task automatic drain();
        while (exp_op.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // Results are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst_i && wb_valid_o) begin
            if (exp_op.size() == 0) begin
                errors++;
                $display("Result for register %0d at %0t with no instruction outstanding",
                         wb_waddr_o, $time);
            end else begin
                check_bit("wb_we_o", exp_op[0], exp_we[0], wb_we_o);
                check_reg("wb_waddr_o", exp_op[0], exp_rd[0], wb_waddr_o);
                check_word("wb_wdata_o", exp_op[0], exp_data[0], wb_wdata_o);
                check_bit("wb_excp_o", exp_op[0], exp_code[0] != '0, wb_excp_o);
                check_excp("wb_excp_code_o", exp_op[0], exp_code[0], wb_excp_code_o);
                void'(exp_op.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_we.pop_front());
                void'(exp_data.pop_front());
                void'(exp_code.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles with %0d results still missing",
                     cycles, exp_op.size());
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int unsigned seed;
        int i;
        int grp;
        int groups;
        int grp_checks;
        int grp_errors;
        $timeformat(-9, 0, " ns", 0);
        seed            = 32'h786a0218;
        void'($urandom(seed));
        rst_i           = 1'b1;
        ex_valid_i      = 1'b0;
        ex_op_i         = '0;
        ex_addr_i       = '0;
        ex_wdata_i      = '0;
        ex_waddr_i      = '0;
        cfg_we_i        = 1'b0;
        cfg_align_chk_i = 1'b1;
        llbit_clr_i     = 1'b0;
        load_stim();
        cycle_limit = 20 * n_lines + 100;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // Quiet outputs until the first issue
        repeat (4) begin
            check_bit("wb_valid_o", 4'd0, 1'b0, wb_valid_o);
            check_bit("stall_o", 4'd0, 1'b0, stall_o);
            @(negedge clk);
        end
        $display("group 0 (%s): %0d checks, %0d errors", group_name(0), checks, errors);
        groups = 1;

        i = 0;
        while (i < n_lines) begin
            grp        = field(i, 0);
            grp_checks = checks;
            grp_errors = errors;
            stall_hits = 0;
            burst_seen = 1'b0;
            while (i < n_lines && field(i, 0) == grp) begin
                run_line(i);
                i++;
            end
            ex_valid_i = 1'b0;
            drain();
            if (burst_seen && stall_hits == 0) begin
                errors++;
                $display("The burst in group %0d never saw stall_o high", grp);
            end
            $display("group %0d (%s): %0d checks, %0d errors", grp, group_name(grp),
                     checks - grp_checks, errors - grp_errors);
            groups++;
        end

        if (dut_i.stage_i.chk_i.fail_cnt != 0) begin
            errors += dut_i.stage_i.chk_i.fail_cnt;
            $display("%0d assertion failures in the bound checker",
                     dut_i.stage_i.chk_i.fail_cnt);
        end
        $display("Done: %0d groups, %0d checks, %0d errors", groups, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mem_chk (
    input logic                           clk,
    input logic                           rst_i,
    input logic [mem_pkg::CREDIT_W-1:0]   credit_cnt_i,
    input logic                           req_valid_i,
    input logic                           credit_ret_i,
    input logic                           ex_valid_i,
    input logic                           stall_i,
    input logic                           wb_valid_i
);
    import mem_pkg::*;

    int fail_cnt = 0;
    int credits_left;
    int outstanding;

    // Own view of the credit pool and of accepted instructions
    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits_left <= MEM_CREDITS;
            outstanding  <= 0;
        end else begin
            credits_left <= credits_left - int'(req_valid_i) + int'(credit_ret_i);
            outstanding  <= outstanding + int'(ex_valid_i && !stall_i) - int'(wb_valid_i);
        end
    end

    // Credits only come back for requests already sent
    credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        credit_cnt_i <= CREDIT_W'(MEM_CREDITS))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("credit count %0d above pool of %0d", credit_cnt_i, MEM_CREDITS);
        end

    req_has_credit: assert property (@(posedge clk) disable iff (rst_i)
        req_valid_i |-> credits_left > 0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("request issued with no credit left");
        end

    // Every result belongs to an accepted instruction
    wb_from_pending: assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_i |-> outstanding > 0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("writeback with an empty pending queue");
        end

endmodule

bind mem_stage mem_chk chk_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .credit_cnt_i (credit_cnt),
    .req_valid_i  (req_valid_o),
    .credit_ret_i (credit_ret_i),
    .ex_valid_i   (ex_valid_i),
    .stall_i      (stall_o),
    .wb_valid_i   (wb_valid_o)
);

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                ex_valid_i,
    input  mem_pkg::mem_op_t    ex_op_i,
    input  mem_pkg::addr_t      ex_addr_i,
    input  mem_pkg::word_t      ex_wdata_i,
    input  mem_pkg::reg_idx_t   ex_waddr_i,
    output logic                stall_o,
    input  logic                cfg_we_i,
    input  logic                cfg_align_chk_i,
    input  logic                llbit_clr_i,
    output logic                wb_valid_o,
    output logic                wb_we_o,
    output mem_pkg::reg_idx_t   wb_waddr_o,
    output mem_pkg::word_t      wb_wdata_o,
    output logic                wb_excp_o,
    output mem_pkg::excp_code_t wb_excp_code_o
);
    import mem_pkg::*;

    logic     req_valid;
    logic     req_we;
    addr_t    req_addr;
    byte_en_t req_be;
    word_t    req_data;
    logic     credit_ret;
    logic     rsp_valid;
    word_t    rsp_data;
    logic     align_chk_en;
    logic     llbit;
    logic     ll_set;
    logic     sc_clear;

    mem_stage stage_i (
        .clk, .rst_i,
        .ex_valid_i, .ex_op_i, .ex_addr_i, .ex_wdata_i, .ex_waddr_i, .stall_o,
        .req_valid_o(req_valid), .req_we_o(req_we), .req_addr_o(req_addr),
        .req_be_o(req_be), .req_data_o(req_data),
        .credit_ret_i(credit_ret), .rsp_valid_i(rsp_valid), .rsp_data_i(rsp_data),
        .align_chk_en_i(align_chk_en), .llbit_i(llbit),
        .ll_set_o(ll_set), .sc_clear_o(sc_clear),
        .wb_valid_o, .wb_we_o, .wb_waddr_o, .wb_wdata_o, .wb_excp_o, .wb_excp_code_o
    );

    mem_cfg_regs cfg_i (
        .clk, .rst_i,
        .cfg_we_i, .cfg_align_chk_i, .llbit_clr_i,
        .ll_set_i(ll_set), .sc_clear_i(sc_clear),
        .align_chk_en_o(align_chk_en), .llbit_o(llbit)
    );

    data_sram sram_i (
        .clk, .rst_i,
        .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
        .req_be_i(req_be), .req_data_i(req_data),
        .credit_ret_o(credit_ret), .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data)
    );

endmodule

`default_nettype wire

//--- source/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  logic              req_we_i,
    input  mem_pkg::addr_t    req_addr_i,
    input  mem_pkg::byte_en_t req_be_i,
    input  mem_pkg::word_t    req_data_i,
    output logic              credit_ret_o,
    output logic              rsp_valid_o,
    output mem_pkg::word_t    rsp_data_o
);
    import mem_pkg::*;

    logic               q_we   [MEM_CREDITS];
    logic [SRAM_AW-1:0] q_addr [MEM_CREDITS];
    byte_en_t           q_be   [MEM_CREDITS];
    word_t              q_data [MEM_CREDITS];
    logic [QUEUE_AW-1:0] q_wr_ptr;
    logic [QUEUE_AW-1:0] q_rd_ptr;
    logic [CREDIT_W-1:0] q_cnt;
    logic pushed_q;
    logic pop;
    word_t mem [2**SRAM_AW] = '{default: '0};

    // A request that just arrived sits one cycle before it can leave
    assign pop          = q_cnt > 1 || (q_cnt == 1 && !pushed_q);
    assign credit_ret_o = pop;

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            q_we[q_wr_ptr]   <= req_we_i;
            q_addr[q_wr_ptr] <= req_addr_i[SRAM_AW+1:2];
            q_be[q_wr_ptr]   <= req_be_i;
            q_data[q_wr_ptr] <= req_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
            pushed_q <= 1'b0;
        end else begin
            if (req_valid_i) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (pop) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_cnt    <= q_cnt + CREDIT_W'(req_valid_i) - CREDIT_W'(pop);
            pushed_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && q_we[q_rd_ptr]) begin
            for (int b = 0; b < 4; b++) begin
                if (q_be[q_rd_ptr][b]) begin
                    mem[q_addr[q_rd_ptr]][b*8 +: 8] <= q_data[q_rd_ptr][b*8 +: 8];
                end
            end
        end
        if (pop && !q_we[q_rd_ptr]) begin
            rsp_data_o <= mem[q_addr[q_rd_ptr]];
        end
    end

    // Writes are silent
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= pop && !q_we[q_rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- source/mem_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_cfg_regs (
    input  logic clk,
    input  logic rst_i,
    input  logic cfg_we_i,
    input  logic cfg_align_chk_i,
    input  logic llbit_clr_i,
    input  logic ll_set_i,
    input  logic sc_clear_i,
    output logic align_chk_en_o,
    output logic llbit_o
);

    // Checking is on out of reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            align_chk_en_o <= 1'b1;
        end else if (cfg_we_i) begin
            align_chk_en_o <= cfg_align_chk_i;
        end
    end

    // LL wins over any clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            llbit_o <= 1'b0;
        end else if (ll_set_i) begin
            llbit_o <= 1'b1;
        end else if (sc_clear_i || llbit_clr_i) begin
            llbit_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                ex_valid_i,
    input  mem_pkg::mem_op_t    ex_op_i,
    input  mem_pkg::addr_t      ex_addr_i,
    input  mem_pkg::word_t      ex_wdata_i,
    input  mem_pkg::reg_idx_t   ex_waddr_i,
    output logic                stall_o,
    output logic                req_valid_o,
    output logic                req_we_o,
    output mem_pkg::addr_t      req_addr_o,
    output mem_pkg::byte_en_t   req_be_o,
    output mem_pkg::word_t      req_data_o,
    input  logic                credit_ret_i,
    input  logic                rsp_valid_i,
    input  mem_pkg::word_t      rsp_data_i,
    input  logic                align_chk_en_i,
    input  logic                llbit_i,
    output logic                ll_set_o,
    output logic                sc_clear_o,
    output logic                wb_valid_o,
    output logic                wb_we_o,
    output mem_pkg::reg_idx_t   wb_waddr_o,
    output mem_pkg::word_t      wb_wdata_o,
    output logic                wb_excp_o,
    output mem_pkg::excp_code_t wb_excp_code_o
);
    import mem_pkg::*;

    logic is_load;
    logic is_store;
    logic is_half;
    logic is_word;
    logic misalign;
    logic sc_fail;
    logic need_mem;
    logic accept;
    logic pend_full;
    logic [CREDIT_W-1:0] credit_cnt;
    logic [PEND_CW-1:0]  pend_cnt;
    logic [PEND_AW-1:0]  wr_ptr;
    logic [PEND_AW-1:0]  rd_ptr;
    word_t lane;
    word_t ld_data;

    // Pending queue payload
    mem_op_t    pq_op    [PEND_DEPTH];
    logic [1:0] pq_lo    [PEND_DEPTH];
    reg_idx_t   pq_waddr [PEND_DEPTH];
    logic       pq_rd    [PEND_DEPTH];
    logic       pq_we    [PEND_DEPTH];
    logic       pq_excp  [PEND_DEPTH];
    logic       pq_one   [PEND_DEPTH];

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (ex_op_i)
            OP_LD_B, OP_LD_BU: is_load = 1'b1;
            OP_LD_H, OP_LD_HU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            OP_LD_W, OP_LL: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            OP_ST_B: is_store = 1'b1;
            OP_ST_H: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            OP_ST_W, OP_SC: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;
        endcase
    end

    assign misalign = (is_half && ex_addr_i[0]) || (is_word && ex_addr_i[1:0] != 2'b00);
    assign sc_fail  = (ex_op_i == OP_SC) && !llbit_i;
    assign need_mem = (is_load || is_store) && !misalign && !sc_fail;

    // Lane strobes, store data copied to every lane
    always_comb begin
        if (is_word) begin
            req_be_o   = 4'b1111;
            req_data_o = ex_wdata_i;
        end else if (is_half) begin
            req_be_o   = ex_addr_i[1] ? 4'b1100 : 4'b0011;
            req_data_o = {2{ex_wdata_i[15:0]}};
        end else begin
            req_be_o   = 4'b0001 << ex_addr_i[1:0];
            req_data_o = {4{ex_wdata_i[7:0]}};
        end
    end

    assign pend_full   = pend_cnt == PEND_CW'(PEND_DEPTH);
    assign stall_o     = ex_valid_i && (pend_full || (need_mem && credit_cnt == '0));
    assign accept      = ex_valid_i && !stall_o;
    assign req_valid_o = accept && need_mem;
    assign req_we_o    = is_store;
    assign req_addr_o  = ex_addr_i;
    assign ll_set_o    = req_valid_o && ex_op_i == OP_LL;
    assign sc_clear_o  = req_valid_o && ex_op_i == OP_SC;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credit_cnt <= CREDIT_W'(MEM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CREDIT_W'(req_valid_o) + CREDIT_W'(credit_ret_i);
        end
    end

    // Outcome is fixed at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            pq_op[wr_ptr]    <= ex_op_i;
            pq_lo[wr_ptr]    <= ex_addr_i[1:0];
            pq_waddr[wr_ptr] <= ex_waddr_i;
            pq_rd[wr_ptr]    <= need_mem && is_load;
            pq_excp[wr_ptr]  <= misalign && align_chk_en_i;
            pq_we[wr_ptr]    <= (is_load || ex_op_i == OP_SC) && !misalign
                                || is_load && !align_chk_en_i;
            pq_one[wr_ptr]   <= ex_op_i == OP_SC && llbit_i && !misalign;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            pend_cnt <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (wb_valid_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            pend_cnt <= pend_cnt + PEND_CW'(accept) - PEND_CW'(wb_valid_o);
        end
    end

    // Head waits only on a read
    assign wb_valid_o = pend_cnt != '0 && (!pq_rd[rd_ptr] || rsp_valid_i);

    always_comb begin
        lane = rsp_data_i >> {pq_lo[rd_ptr], 3'b000};
        case (pq_op[rd_ptr])
            OP_LD_B:  ld_data = {{24{lane[7]}}, lane[7:0]};
            OP_LD_BU: ld_data = {24'b0, lane[7:0]};
            OP_LD_H:  ld_data = {{16{lane[15]}}, lane[15:0]};
            OP_LD_HU: ld_data = {16'b0, lane[15:0]};
            default:  ld_data = rsp_data_i;
        endcase
    end

    assign wb_we_o        = pq_we[rd_ptr];
    assign wb_waddr_o     = pq_waddr[rd_ptr];
    assign wb_wdata_o     = pq_rd[rd_ptr] ? ld_data : {31'b0, pq_one[rd_ptr]};
    assign wb_excp_o      = pq_excp[rd_ptr];
    assign wb_excp_code_o = pq_excp[rd_ptr] ? EXC_ALE : '0;

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  mem_op_t;
    typedef logic [5:0]  excp_code_t;
    // Short op tag, checker side
    typedef logic [2:0]  op_t;

    // Loads occupy 1..6, stores 7..10
    localparam mem_op_t OP_LD_B  = 4'd1;
    localparam mem_op_t OP_LD_BU = 4'd2;
    localparam mem_op_t OP_LD_H  = 4'd3;
    localparam mem_op_t OP_LD_HU = 4'd4;
    localparam mem_op_t OP_LD_W  = 4'd5;
    localparam mem_op_t OP_LL    = 4'd6;
    localparam mem_op_t OP_ST_B  = 4'd7;
    localparam mem_op_t OP_ST_H  = 4'd8;
    localparam mem_op_t OP_ST_W  = 4'd9;
    localparam mem_op_t OP_SC    = 4'd10;

    // SRAM request queue depth, equal to the credit pool
    localparam int MEM_CREDITS = 2;
    localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);
    localparam int QUEUE_AW    = $clog2(MEM_CREDITS);

    // Instructions in flight inside the stage
    localparam int PEND_DEPTH  = 4;
    localparam int PEND_AW     = $clog2(PEND_DEPTH);
    localparam int PEND_CW     = $clog2(PEND_DEPTH + 1);

    // Word address bits of the data SRAM
    localparam int SRAM_AW     = 8;

    // Address misaligned
    localparam excp_code_t EXC_ALE = 6'h09;

endpackage

`default_nettype wire
